/* tb.f */
logic/fscpu_pkg.sv
logic/motor_param_bank.sv
logic/device_sequencer.sv
logic/motor_drive.sv
logic/fscpu.sv
dv/fscpu_props.sv
dv/tb_fscpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fscpu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_fscpu \
	-f tb.f \
	-o sim_fscpu

./obj_dir/sim_fscpu > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* dv/tb_fscpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fscpu;

	logic                                              clk;
	logic                                              resetn;
	logic                                              req_en;
	fscpu_pkg::req_t                                   req;
	logic                                              req_done;
	bit [fscpu_pkg::num_motors-1:0]                    motor_busy;	// motor model output
	fscpu_pkg::motor_out_t [fscpu_pkg::num_motors-1:0] motor;

	logic [31:0] rng       = 32'd13;	// stimulus words
	logic [31:0] model_rng = 32'd13;	// busy lengths
	bit   [fscpu_pkg::num_motors-1:0] long_busy;

	int unsigned           busy_cnt    [fscpu_pkg::num_motors];
	int unsigned           start_count [fscpu_pkg::num_motors];
	int unsigned           exp_starts  [fscpu_pkg::num_motors];
	fscpu_pkg::motor_out_t exp_move    [fscpu_pkg::num_motors];

	fscpu i_fscpu (
		.clk        (clk),
		.resetn     (resetn),
		.req_en     (req_en),
		.req        (req),
		.req_done   (req_done),
		.motor_busy (motor_busy),
		.motor      (motor)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// what the motor should see for a recorded request
	function automatic fscpu_pkg::motor_out_t expected_move(input fscpu_pkg::req_t r);
		fscpu_pkg::motor_out_t m;
		m       = '0;
		m.speed = r.par1;
		m.step  = r.par2;
		m.dir   = r.par0[1];
		return m;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want)
			fail_run($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
				$time, what, got, want));
	endtask

	// busy for a random time after each start
	always @(posedge clk) begin
		for (int m = 0; m < fscpu_pkg::num_motors; m++) begin
			if (!resetn) begin
				motor_busy[m] <= 1'b0;
				busy_cnt[m]   <= 0;
			end else if (motor[m].start) begin
				model_rng = xorshift32(model_rng);
				motor_busy[m] <= 1'b1;
				busy_cnt[m]   <= long_busy[m] ? 500 : 3 + model_rng % 18;
			end else if (motor_busy[m]) begin
				if (motor[m].stop || busy_cnt[m] <= 1) begin
					motor_busy[m] <= 1'b0;	// done or aborted
					busy_cnt[m]   <= 0;
				end else begin
					busy_cnt[m] <= busy_cnt[m] - 1;
				end
			end
		end
	end

	// compare every start pulse with the latest record
	always @(posedge clk) begin
		for (int m = 0; m < fscpu_pkg::num_motors; m++) begin
			if (resetn && motor[m].start) begin
				check_value($sformatf("ch%0d sel", m), 64'(motor[m].sel), 64'd1);
				check_value($sformatf("ch%0d speed", m), 64'(motor[m].speed),
					64'(exp_move[m].speed));
				check_value($sformatf("ch%0d step", m), 64'(motor[m].step),
					64'(exp_move[m].step));
				check_value($sformatf("ch%0d dir", m), 64'(motor[m].dir),
					64'(exp_move[m].dir));
				start_count[m] <= start_count[m] + 1;
			end
		end
	end

	task automatic send_req(input fscpu_pkg::req_t r);
		@(posedge clk);
		req_en <= 1'b1;
		req    <= r;
		@(posedge clk);
		req_en <= 1'b0;
	endtask

	task automatic send_cmd(input int code);
		fscpu_pkg::req_t r;
		r     = '0;
		r.cmd = 32'(code);
		send_req(r);
	endtask

	task automatic record_channel(input int ch);
		fscpu_pkg::req_t r;
		r.cmd  = 32'(ch);
		rng    = xorshift32(rng);
		r.par0 = rng;
		rng    = xorshift32(rng);
		r.par1 = rng;
		rng    = xorshift32(rng);
		r.par2 = rng;
		rng    = xorshift32(rng);
		r.par3 = rng;
		exp_move[ch] = expected_move(r);
		send_req(r);
	endtask

	task automatic check_starts();
		for (int m = 0; m < fscpu_pkg::num_motors; m++)
			check_value($sformatf("ch%0d start count", m), 64'(start_count[m]),
				64'(exp_starts[m]));
	endtask

	task automatic wait_req_done(input int limit);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			if (req_done && motor_busy != '0)
				fail_run("req_done went high while a motor was still busy");
			n++;
			if (n > limit)
				fail_run($sformatf("timeout: req_done did not rise within %0d cycles", limit));
		end while (!req_done);
	endtask

	task automatic wait_busy_level(input int ch, input logic level, input int limit);
		int n;
		n = 0;
		while (motor_busy[ch] != level) begin
			@(posedge clk);
			n++;
			if (n > limit)
				fail_run($sformatf("timeout: busy of channel %0d never went to %0d", ch, level));
		end
	endtask

	task automatic wait_stop(input int ch, input int limit);
		int n;
		n = 0;
		while (!motor[ch].stop) begin
			@(posedge clk);
			n++;
			if (n > limit)
				fail_run($sformatf("timeout: channel %0d never raised stop", ch));
		end
		check_value("sel during stop", 64'(motor[ch].sel), 64'd0);
	endtask

	task automatic run_and_wait(input fscpu_pkg::dev_bmp_t chans);
		send_cmd(fscpu_pkg::req_exe);
		for (int m = 0; m < fscpu_pkg::num_motors; m++)
			if (chans[m])
				exp_starts[m] = exp_starts[m] + 1;
		wait_req_done(200);
		check_starts();
	endtask

	initial begin
		fscpu_pkg::dev_bmp_t chans;
		logic [31:0]         pick;
		resetn <= 1'b0;
		req_en <= 1'b0;
		req    <= '0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		// single move on left push
		record_channel(fscpu_pkg::motor_lp);
		run_and_wait(4'b0001);

		record_channel(fscpu_pkg::motor_rp);
		record_channel(fscpu_pkg::motor_xa);
		record_channel(fscpu_pkg::motor_ya);
		run_and_wait(4'b1110);

		// frame delay code wipes staging
		record_channel(fscpu_pkg::motor_lp);
		send_cmd(fscpu_pkg::req_frm_dly);
		send_cmd(fscpu_pkg::req_exe);
		repeat (40) begin
			@(posedge clk);
			check_value("req_done after empty execute", 64'(req_done), 64'd0);
		end
		check_starts();

		// abort a long move on x align
		long_busy[fscpu_pkg::motor_xa] = 1'b1;
		record_channel(fscpu_pkg::motor_xa);
		send_cmd(fscpu_pkg::req_exe);
		exp_starts[fscpu_pkg::motor_xa] = exp_starts[fscpu_pkg::motor_xa] + 1;
		wait_busy_level(fscpu_pkg::motor_xa, 1'b1, 20);
		send_cmd(fscpu_pkg::req_stop);
		wait_stop(fscpu_pkg::motor_xa, 20);
		wait_busy_level(fscpu_pkg::motor_xa, 1'b0, 20);
		long_busy[fscpu_pkg::motor_xa] = 1'b0;
		repeat (40) begin
			@(posedge clk);
			check_value("req_done after stop", 64'(req_done), 64'd0);
		end
		check_starts();

		for (int round = 0; round < 20; round++) begin
			rng   = xorshift32(rng);
			pick  = rng;
			chans = pick[3:0];
			if (chans == '0)
				chans = pick[7:4] | 4'b0001;
			for (int m = 0; m < fscpu_pkg::num_motors; m++) begin
				if (chans[m]) begin
					record_channel(m);
					if (pick[8+m])
						record_channel(m);	// overwrite so the latest wins
				end
			end
			run_and_wait(chans);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/fscpu_props.sv */
`timescale 1ns/10ps
`default_nettype none

module fscpu_props (
	input logic                                              clk,
	input logic                                              resetn,
	input logic                                              req_en,
	input logic                                              req_done,
	input fscpu_pkg::dev_bmp_t                               motor_busy,
	input fscpu_pkg::motor_out_t [fscpu_pkg::num_motors-1:0] motor
);

	a_done_cleared: assert property (@(posedge clk) disable iff (!resetn)
		req_en |=> !req_done)
		else $error("req_done high the cycle after a request");

	// completion only once every motor is idle
	a_done_idle: assert property (@(posedge clk) disable iff (!resetn)
		$rose(req_done) |-> (motor_busy == '0))
		else $error("req_done rose while a motor was busy");

	genvar i;
	generate
		for (i = 0; i < fscpu_pkg::num_motors; i = i + 1) begin : g_chan
			a_start_pulse: assert property (@(posedge clk) disable iff (!resetn)
				motor[i].start |=> !motor[i].start)
				else $error("start longer than one cycle on channel %0d", i);

			a_sel_stop: assert property (@(posedge clk) disable iff (!resetn)
				!(motor[i].sel && motor[i].stop))
				else $error("sel and stop high together on channel %0d", i);
		end
	endgenerate

endmodule

bind fscpu fscpu_props i_props (
	.clk        (clk),
	.resetn     (resetn),
	.req_en     (req_en),
	.req_done   (req_done),
	.motor_busy (motor_busy),
	.motor      (motor)
);

`default_nettype wire

/* logic/fscpu.sv */
`timescale 1ns/10ps
`default_nettype none

module fscpu (
	input  logic                                              clk,
	input  logic                                              resetn,
	input  logic                                              req_en,
	input  fscpu_pkg::req_t                                   req,
	output logic                                              req_done,
	input  fscpu_pkg::dev_bmp_t                               motor_busy,
	output fscpu_pkg::motor_out_t [fscpu_pkg::num_motors-1:0] motor
);

	fscpu_pkg::motor_cmd_t [fscpu_pkg::num_motors-1:0] motor_cmd;
	fscpu_pkg::dev_bmp_t                               oper;
	fscpu_pkg::dev_bmp_t                               done;

	// recorded parameters
	motor_param_bank i_param_bank (
		.clk    (clk),
		.resetn (resetn),
		.req_en (req_en),
		.req    (req),
		.cmd    (motor_cmd)
	);

	// staging, run bitmap and completion
	device_sequencer i_dev_seq (
		.clk      (clk),
		.resetn   (resetn),
		.req_en   (req_en),
		.req_cmd  (req.cmd),
		.done     (done),
		.oper     (oper),
		.req_done (req_done)
	);

	// lp, rp, xa, ya in index order
	genvar i;
	generate
		for (i = 0; i < fscpu_pkg::num_motors; i = i + 1) begin : g_drive
			motor_drive i_drive (
				.clk    (clk),
				.resetn (resetn),
				.enable (oper[i]),
				.cmd    (motor_cmd[i]),
				.busy   (motor_busy[i]),
				.done   (done[i]),
				.motor  (motor[i])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* logic/motor_drive.sv */
`timescale 1ns/10ps
`default_nettype none

module motor_drive (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  enable,
	input  fscpu_pkg::motor_cmd_t cmd,
	input  logic                  busy,
	output logic                  done,
	output fscpu_pkg::motor_out_t motor
);

	typedef enum logic [2:0] {
		st_idle,
		st_launch,
		st_wait_busy,
		st_wait_idle,
		st_finished
	} state_t;

	state_t                state;
	state_t                state_nxt;
	fscpu_pkg::motor_cmd_t move;	// held for the whole move

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (enable)
					state_nxt = st_launch;
			end
			st_launch: begin
				state_nxt = st_wait_busy;
			end
			st_wait_busy: begin
				if (busy)
					state_nxt = st_wait_idle;
			end
			st_wait_idle: begin
				if (!busy)
					state_nxt = st_finished;
			end
			st_finished: begin
				state_nxt = st_finished;	// until enable drops
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
		if (!enable)
			state_nxt = st_idle;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	// capture the move on the way into launch
	always_ff @(posedge clk) begin
		if (state == st_idle && enable)
			move <= cmd;
	end

	assign done = (state == st_finished);

	// motor side
	assign motor.sel   = enable && (state != st_idle);
	assign motor.start = enable && (state == st_launch);	// one cycle
	assign motor.stop  = !enable && busy;	// abort a move still running
	assign motor.speed = move.speed;
	assign motor.step  = move.step;
	assign motor.dir   = move.dir;

endmodule

`default_nettype wire

/* logic/device_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module device_sequencer (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        req_en,
	input  logic [fscpu_pkg::cmd_w-1:0] req_cmd,
	input  fscpu_pkg::dev_bmp_t         done,
	output fscpu_pkg::dev_bmp_t         oper,
	output logic                        req_done
);

	fscpu_pkg::dev_bmp_t staging;
	fscpu_pkg::dev_bmp_t rec_bit;	// channel named by a record command

	logic is_record;
	logic is_exe;
	logic is_stop;
	logic all_done;

	// command decode
	assign is_record = (req_cmd < fscpu_pkg::num_motors);
	assign is_exe    = (req_cmd == fscpu_pkg::req_exe);
	assign is_stop   = (req_cmd == fscpu_pkg::req_stop);

	always_comb begin
		rec_bit = '0;
		rec_bit[req_cmd[fscpu_pkg::motor_idx_w-1:0]] = 1'b1;
	end

	// every running channel has reported
	assign all_done = (oper != '0) && ((done & oper) == oper);

	// staging bitmap, built up by record commands
	always_ff @(posedge clk) begin
		if (!resetn) begin
			staging <= '0;
		end else if (req_en) begin
			if (is_record)
				staging <= staging | rec_bit;
			else
				staging <= '0;	// exe, stop, frame delay and unknown codes
		end else if (all_done) begin
			staging <= '0;
		end
	end

	// running bitmap
	always_ff @(posedge clk) begin
		if (!resetn) begin
			oper <= '0;
		end else if (req_en) begin
			if (is_exe)
				oper <= staging;
			else if (is_stop)
				oper <= '0;
		end else if (all_done) begin
			oper <= '0;	// drops the drives back to idle
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			req_done <= 1'b0;
		else if (req_en)
			req_done <= 1'b0;	// any new request
		else if (all_done)
			req_done <= 1'b1;
	end

endmodule

`default_nettype wire

/* logic/motor_param_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module motor_param_bank (
	input  logic                                              clk,
	input  logic                                              resetn,
	input  logic                                              req_en,
	input  fscpu_pkg::req_t                                   req,
	output fscpu_pkg::motor_cmd_t [fscpu_pkg::num_motors-1:0] cmd
);

	// decoded fields shared by every channel
	logic [fscpu_pkg::speed_w-1:0] req_speed;
	logic [fscpu_pkg::step_w-1:0]  req_step;
	logic                          req_dir;

	assign req_speed = req.par1[fscpu_pkg::speed_w-1:0];
	assign req_step  = req.par2[fscpu_pkg::step_w-1:0];
	assign req_dir   = req.par0[fscpu_pkg::dir_bit];

	genvar i;
	generate
		for (i = 0; i < fscpu_pkg::num_motors; i = i + 1) begin : g_chan
			logic hit;

			// record command code equals channel index
			assign hit = req_en && (req.cmd == i);

			always_ff @(posedge clk) begin
				if (!resetn) begin
					cmd[i] <= '0;
				end else if (hit) begin
					cmd[i].speed <= req_speed;
					cmd[i].step  <= req_step;
					cmd[i].dir   <= req_dir;
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

/* logic/fscpu_pkg.sv */
`default_nettype none

package fscpu_pkg;

	// motor channels
	localparam int num_motors  = 4;
	localparam int motor_idx_w = $clog2(num_motors);

	// channel index doubles as the record command code
	localparam int motor_lp = 0;	// left push
	localparam int motor_rp = 1;	// right push
	localparam int motor_xa = 2;	// x align
	localparam int motor_ya = 3;	// y align

	// control commands
	localparam int req_frm_dly = 29;	// clears staging only
	localparam int req_exe     = 30;
	localparam int req_stop    = 31;

	localparam int cmd_w   = 32;
	localparam int par_w   = 32;
	localparam int speed_w = 32;
	localparam int step_w  = 32;

	// bit 1 of par0 selects the move direction
	localparam int dir_bit = 1;

	typedef logic [num_motors-1:0] dev_bmp_t;

	// one host request
	typedef struct packed {
		logic [cmd_w-1:0] cmd;
		logic [par_w-1:0] par0;	// flags
		logic [par_w-1:0] par1;	// speed
		logic [par_w-1:0] par2;	// step count
		logic [par_w-1:0] par3;	// unused here
	} req_t;

	// recorded move of one channel
	typedef struct packed {
		logic [speed_w-1:0] speed;
		logic [step_w-1:0]  step;
		logic               dir;
	} motor_cmd_t;

	// toward one motor
	typedef struct packed {
		logic               sel;
		logic               start;
		logic               stop;
		logic [speed_w-1:0] speed;
		logic [step_w-1:0]  step;
		logic               dir;
	} motor_out_t;

endpackage

`default_nettype wire
